// File: hdl/openadc_defines.svh
`ifndef OPENADC_DEFINES_SVH
`define OPENADC_DEFINES_SVH

// Host bus widths
`define OADC_ADDR_W 6
`define OADC_DATA_W 8

// Measurement and capture widths
`define OADC_FREQ_W 32
`define OADC_SAMPLES_W 16

// Gate window length, log2 of slow clock cycles
`define OADC_GATE_LOG2_DEFAULT 25

// Register map
`define OADC_REG_GAIN 6'd0
`define OADC_REG_SETTINGS 6'd1
`define OADC_REG_STATUS 6'd2
`define OADC_REG_FREQ0 6'd3 // LSB first
`define OADC_REG_FREQ1 6'd4
`define OADC_REG_FREQ2 6'd5
`define OADC_REG_FREQ3 6'd6
`define OADC_REG_SAMPLES0 6'd7
`define OADC_REG_SAMPLES1 6'd8

// Settings register bits
`define OADC_SET_HILO 0
`define OADC_SET_ARM 1 // Rising edge arms
`define OADC_SET_TRIG_HIGH 2 // 1 = high active trigger
`define OADC_SET_TRIG_WAIT 3
`define OADC_SET_TRIG_NOW 4

// Status register bits
`define OADC_ST_ARMED 0
`define OADC_ST_IDLE 1
`define OADC_ST_TRIG_IN 2

`endif

// File: hdl/openadc_pkg.sv
`include "openadc_defines.svh"

package openadc_pkg;

	// Host register address
	typedef logic [`OADC_ADDR_W-1:0] reg_addr_t;

	// One host register byte
	typedef logic [`OADC_DATA_W-1:0] reg_data_t;

	// External clock edges seen in one gate window
	typedef logic [`OADC_FREQ_W-1:0] freq_count_t;

	// Capture window length in slow clock cycles
	typedef logic [`OADC_SAMPLES_W-1:0] sample_count_t;

	// Trigger unit FSM
	// idle          waiting for an arm edge
	// wait_inactive armed, but trigger must go inactive first
	// armed         waiting for trigger or force
	// capturing     capture window open
	typedef enum logic [1:0] {
		st_idle          = 2'd0,
		st_wait_inactive = 2'd1,
		st_armed         = 2'd2,
		st_capturing     = 2'd3
	} trig_state_t;

endpackage

// File: hdl/timebase.sv
`timescale 1ns/100ps
`include "openadc_defines.svh"

module timebase #(
	parameter int unsigned gate_log2 = `OADC_GATE_LOG2_DEFAULT
) (
	input  logic slowclock,
	input  logic freq_measure, // Async, active low
	output logic gate_window_o,
	output logic heartbeat_o
);

	// One bit above the gate length, so the top bit is a square wave
	logic [gate_log2:0] timer_q;

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			timer_q <= '0;
		end else begin
			timer_q <= timer_q + 1'b1; // Free running, wraps
		end
	end

	// High for 2**gate_log2 cycles, low for as long
	assign gate_window_o = timer_q[gate_log2];

	// Half the gate period per toggle
	assign heartbeat_o = timer_q[gate_log2-1];

endmodule

// File: hdl/extclk_counter.sv
`timescale 1ns/100ps

module extclk_counter (
	input  logic                     slowclock,
	input  logic                     freq_measure,
	input  logic                     ext_clk_i, // Target clock, unrelated to slowclock
	input  logic                     gate_window_i,
	output openadc_pkg::freq_count_t freq_result_o
);

	// External clock domain
	logic                     gate_s1_q;
	logic                     gate_s2_q;
	logic                     gate_d_q; // Delayed copy for fall detect
	logic                     gate_fall;
	openadc_pkg::freq_count_t count_q;
	openadc_pkg::freq_count_t hold_q; // Stable while toggle crosses over
	logic                     toggle_q;

	// Slow clock domain
	logic                     tog_s1_q;
	logic                     tog_s2_q;
	logic                     tog_d_q;
	logic                     tog_edge;

	// Gate into the target clock domain, two flops
	always_ff @(posedge ext_clk_i or negedge freq_measure) begin
		if (!freq_measure) begin
			gate_s1_q <= 1'b0;
			gate_s2_q <= 1'b0;
			gate_d_q  <= 1'b0;
		end else begin
			gate_s1_q <= gate_window_i;
			gate_s2_q <= gate_s1_q;
			gate_d_q  <= gate_s2_q;
		end
	end

	assign gate_fall = gate_d_q & ~gate_s2_q;

	// Edge counter and toggle flag
	always_ff @(posedge ext_clk_i or negedge freq_measure) begin
		if (!freq_measure) begin
			count_q  <= '0;
			toggle_q <= 1'b0;
		end else begin
			if (gate_s2_q) begin
				count_q <= count_q + 1'b1;
			end else if (gate_fall) begin
				count_q  <= '0; // Ready for next window
				toggle_q <= ~toggle_q; // Tell slow side a result is waiting
			end
		end
	end

	// Result snapshot at gate fall
	always_ff @(posedge ext_clk_i or negedge freq_measure) begin
		if (!freq_measure) begin
			hold_q <= '0;
		end else if (gate_fall) begin
			hold_q <= count_q;
		end
	end

	// Toggle into slowclock domain
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			tog_s1_q <= 1'b0;
			tog_s2_q <= 1'b0;
			tog_d_q  <= 1'b0;
		end else begin
			tog_s1_q <= toggle_q;
			tog_s2_q <= tog_s1_q;
			tog_d_q  <= tog_s2_q;
		end
	end

	// Either edge of the toggle means a new result
	assign tog_edge = tog_s2_q ^ tog_d_q;

	// hold_q has been stable for at least two slow cycles here
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			freq_result_o <= '0;
		end else if (tog_edge) begin
			freq_result_o <= hold_q;
		end
	end

endmodule

// File: hdl/trigger_unit.sv
`timescale 1ns/100ps

module trigger_unit (
	input  logic                       slowclock,
	input  logic                       freq_measure,
	input  logic                       ext_trigger_i, // Asynchronous
	input  logic                       arm_i,
	input  logic                       trig_high_i, // 1 = trigger on high level
	input  logic                       trig_wait_i,
	input  logic                       trig_now_i, // Force trigger
	input  openadc_pkg::sample_count_t max_samples_i,
	output logic                       armed_o,
	output logic                       capture_go_o,
	output logic                       trig_in_sync_o
);

	logic                       trig_s1_q;
	logic                       trig_s2_q;
	logic                       arm_d_q;
	logic                       arm_rise;
	logic                       trig_active;
	openadc_pkg::trig_state_t   state_q;
	openadc_pkg::sample_count_t sample_cnt_q; // Samples left in window

	// Trigger and arm edge registers
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			trig_s1_q <= 1'b0;
			trig_s2_q <= 1'b0;
			arm_d_q   <= 1'b0;
		end else begin
			trig_s1_q <= ext_trigger_i;
			trig_s2_q <= trig_s1_q;
			arm_d_q   <= arm_i;
		end
	end

	assign arm_rise    = arm_i & ~arm_d_q;
	assign trig_active = trig_high_i ? trig_s2_q : ~trig_s2_q; // Polarity select

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			state_q      <= openadc_pkg::st_idle;
			sample_cnt_q <= '0;
		end else begin
			case (state_q)
				openadc_pkg::st_idle: begin
					if (arm_rise) begin
						state_q <= trig_wait_i ? openadc_pkg::st_wait_inactive
						                       : openadc_pkg::st_armed;
					end
				end
				openadc_pkg::st_wait_inactive: begin
					if (!trig_active) state_q <= openadc_pkg::st_armed; // Seen inactive once
				end
				openadc_pkg::st_armed: begin
					if (trig_active || trig_now_i) begin
						state_q      <= openadc_pkg::st_capturing;
						sample_cnt_q <= max_samples_i;
					end
				end
				default: begin
					// Capturing, count down the window
					if (sample_cnt_q <= 1) begin
						state_q <= openadc_pkg::st_idle;
					end else begin
						sample_cnt_q <= sample_cnt_q - 1'b1;
					end
				end
			endcase
		end
	end

	// Armed covers the wait for an inactive trigger too
	assign armed_o = (state_q == openadc_pkg::st_armed) ||
	                 (state_q == openadc_pkg::st_wait_inactive);
	assign capture_go_o   = (state_q == openadc_pkg::st_capturing);
	assign trig_in_sync_o = trig_s2_q;

endmodule

// File: hdl/control_regs.sv
`timescale 1ns/100ps
`include "openadc_defines.svh"

module control_regs (
	input  logic                       slowclock,
	input  logic                       freq_measure,
	input  openadc_pkg::reg_addr_t     reg_addr_i,
	input  openadc_pkg::reg_data_t     reg_wdata_i,
	input  logic                       reg_wr_i,
	input  logic                       reg_rd_i,
	output openadc_pkg::reg_data_t     reg_rdata_o,
	input  openadc_pkg::freq_count_t   freq_result_i,
	input  logic                       armed_i,
	input  logic                       capture_go_i,
	input  logic                       trig_in_sync_i,
	output logic                       arm_o,
	output logic                       trig_high_o,
	output logic                       trig_wait_o,
	output logic                       trig_now_o,
	output openadc_pkg::sample_count_t max_samples_o,
	output logic                       amp_gain_o,
	output logic                       amp_hilo_o
);

	openadc_pkg::reg_data_t gain_q;
	openadc_pkg::reg_data_t settings_q;
	openadc_pkg::reg_data_t status;
	openadc_pkg::reg_data_t rd_mux;
	logic [8:0]             pwm_acc_q; // Bit 8 is the carry out

	// Host writes
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			gain_q        <= '0;
			settings_q    <= '0;
			max_samples_o <= 1; // Never a zero length window
		end else if (reg_wr_i) begin
			case (reg_addr_i)
				`OADC_REG_GAIN:     gain_q <= reg_wdata_i;
				`OADC_REG_SETTINGS: settings_q <= reg_wdata_i;
				`OADC_REG_SAMPLES0: max_samples_o[7:0] <= reg_wdata_i;
				`OADC_REG_SAMPLES1: max_samples_o[15:8] <= reg_wdata_i;
				default: ; // Read only or unmapped
			endcase
		end
	end

	// Status byte, unused bits read zero
	always_comb begin
		status                   = '0;
		status[`OADC_ST_ARMED]   = armed_i;
		status[`OADC_ST_IDLE]    = ~capture_go_i;
		status[`OADC_ST_TRIG_IN] = trig_in_sync_i;
	end

	// Read data select
	always_comb begin
		case (reg_addr_i)
			`OADC_REG_GAIN:     rd_mux = gain_q;
			`OADC_REG_SETTINGS: rd_mux = settings_q;
			`OADC_REG_STATUS:   rd_mux = status;
			`OADC_REG_FREQ0:    rd_mux = freq_result_i[7:0];
			`OADC_REG_FREQ1:    rd_mux = freq_result_i[15:8];
			`OADC_REG_FREQ2:    rd_mux = freq_result_i[23:16];
			`OADC_REG_FREQ3:    rd_mux = freq_result_i[31:24];
			`OADC_REG_SAMPLES0: rd_mux = max_samples_o[7:0];
			`OADC_REG_SAMPLES1: rd_mux = max_samples_o[15:8];
			default:            rd_mux = '0;
		endcase
	end

	// One cycle read latency, held between reads
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			reg_rdata_o <= '0;
		end else if (reg_rd_i) begin
			reg_rdata_o <= rd_mux;
		end
	end

	// Gain PWM
	// Carry fires gain times per 256 cycles
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			pwm_acc_q <= '0;
		end else begin
			pwm_acc_q <= {1'b0, pwm_acc_q[7:0]} + {1'b0, gain_q};
		end
	end

	assign amp_gain_o = pwm_acc_q[8];

	// Settings bits straight out
	assign amp_hilo_o  = settings_q[`OADC_SET_HILO];
	assign arm_o       = settings_q[`OADC_SET_ARM];
	assign trig_high_o = settings_q[`OADC_SET_TRIG_HIGH];
	assign trig_wait_o = settings_q[`OADC_SET_TRIG_WAIT];
	assign trig_now_o  = settings_q[`OADC_SET_TRIG_NOW]; // Level, host clears it

endmodule

// File: hdl/openadc_top.sv
`timescale 1ns/100ps
`include "openadc_defines.svh"

module openadc_top #(
	parameter int unsigned gate_log2 = `OADC_GATE_LOG2_DEFAULT
) (
	input  logic                   slowclock,
	input  logic                   freq_measure, // Async, active low
	input  logic                   dut_clk_i,
	input  logic                   dut_trigger_i,
	input  openadc_pkg::reg_addr_t reg_addr_i,
	input  openadc_pkg::reg_data_t reg_wdata_i,
	input  logic                   reg_wr_i,
	input  logic                   reg_rd_i,
	output openadc_pkg::reg_data_t reg_rdata_o,
	output logic                   led_heartbeat_o,
	output logic                   led_armed_o,
	output logic                   led_capture_o,
	output logic                   amp_gain_o,
	output logic                   amp_hilo_o
);

	logic                       gate_window;
	openadc_pkg::freq_count_t   freq_result;
	logic                       arm;
	logic                       trig_high;
	logic                       trig_wait;
	logic                       trig_now;
	openadc_pkg::sample_count_t max_samples;
	logic                       armed;
	logic                       capture_go;
	logic                       trig_in_sync;

	timebase #(
		.gate_log2(gate_log2)
	) u_timebase (
		.slowclock     (slowclock),
		.freq_measure  (freq_measure),
		.gate_window_o (gate_window),
		.heartbeat_o   (led_heartbeat_o)
	);

	// Target clock frequency
	extclk_counter u_extclk_counter (
		.slowclock     (slowclock),
		.freq_measure  (freq_measure),
		.ext_clk_i     (dut_clk_i),
		.gate_window_i (gate_window),
		.freq_result_o (freq_result)
	);

	trigger_unit u_trigger_unit (
		.slowclock      (slowclock),
		.freq_measure   (freq_measure),
		.ext_trigger_i  (dut_trigger_i),
		.arm_i          (arm),
		.trig_high_i    (trig_high),
		.trig_wait_i    (trig_wait),
		.trig_now_i     (trig_now),
		.max_samples_i  (max_samples),
		.armed_o        (armed),
		.capture_go_o   (capture_go),
		.trig_in_sync_o (trig_in_sync)
	);

	control_regs u_control_regs (
		.slowclock      (slowclock),
		.freq_measure   (freq_measure),
		.reg_addr_i     (reg_addr_i),
		.reg_wdata_i    (reg_wdata_i),
		.reg_wr_i       (reg_wr_i),
		.reg_rd_i       (reg_rd_i),
		.reg_rdata_o    (reg_rdata_o),
		.freq_result_i  (freq_result),
		.armed_i        (armed),
		.capture_go_i   (capture_go),
		.trig_in_sync_i (trig_in_sync),
		.arm_o          (arm),
		.trig_high_o    (trig_high),
		.trig_wait_o    (trig_wait),
		.trig_now_o     (trig_now),
		.max_samples_o  (max_samples),
		.amp_gain_o     (amp_gain_o),
		.amp_hilo_o     (amp_hilo_o)
	);

	// Board LEDs
	assign led_armed_o   = armed;
	assign led_capture_o = capture_go;

endmodule

// File: test/tb_openadc.sv
`timescale 1ns/100ps
`include "openadc_defines.svh"

module tb_openadc;

	localparam int gate_log2   = 6;
	localparam int slow_period = 40; // ns
	localparam int gate_period = 2 << gate_log2; // Slow cycles, high plus low
	localparam int num_gains   = 4;
	// Rough length of all tests in slow cycles
	localparam int run_cycles  = 5 + 100 + num_gains * 270 + 4 * (1 << gate_log2)
	                             + 2 * (3 * gate_period + 20) + 400;

	localparam openadc_pkg::reg_data_t set_hilo = 8'(1 << `OADC_SET_HILO);
	localparam openadc_pkg::reg_data_t set_arm  = 8'(1 << `OADC_SET_ARM);
	localparam openadc_pkg::reg_data_t set_high = 8'(1 << `OADC_SET_TRIG_HIGH);
	localparam openadc_pkg::reg_data_t set_wait = 8'(1 << `OADC_SET_TRIG_WAIT);
	localparam openadc_pkg::reg_data_t set_now  = 8'(1 << `OADC_SET_TRIG_NOW);

	logic                   slowclock;
	logic                   freq_measure;
	logic                   dut_clk;
	logic                   dut_trigger;
	openadc_pkg::reg_addr_t reg_addr;
	openadc_pkg::reg_data_t reg_wdata;
	logic                   reg_wr;
	logic                   reg_rd;
	openadc_pkg::reg_data_t reg_rdata;
	logic                   led_heartbeat;
	logic                   led_armed;
	logic                   led_capture;
	logic                   amp_gain;
	logic                   amp_hilo;
	real                    dut_half = 12.0; // Half period of the target clock
	logic [31:0]            lfsr;
	int                     errors;
	int                     checks;

	openadc_top #(
		.gate_log2(gate_log2)
	) dut (
		.slowclock       (slowclock),
		.freq_measure    (freq_measure),
		.dut_clk_i       (dut_clk),
		.dut_trigger_i   (dut_trigger),
		.reg_addr_i      (reg_addr),
		.reg_wdata_i     (reg_wdata),
		.reg_wr_i        (reg_wr),
		.reg_rd_i        (reg_rd),
		.reg_rdata_o     (reg_rdata),
		.led_heartbeat_o (led_heartbeat),
		.led_armed_o     (led_armed),
		.led_capture_o   (led_capture),
		.amp_gain_o      (amp_gain),
		.amp_hilo_o      (amp_hilo)
	);

	initial begin
		slowclock = 1'b0;
		forever #(slow_period / 2) slowclock = ~slowclock;
	end

	initial begin
		dut_clk = 1'b0;
		forever #(dut_half) dut_clk = ~dut_clk; // Period changes on the fly
	end

	// Watchdog, twice the expected run length
	initial begin
		#(2 * run_cycles * slow_period);
		$display("Timeout: the tests did not finish within %0d slow cycles", 2 * run_cycles);
		$display("Verification failed");
		$finish;
	end

	// Galois LFSR, right shift
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr); // One step per bit
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Reference models
	function automatic int expected_pwm_highs(input openadc_pkg::reg_data_t gain);
		return int'(gain); // One carry per 256 of accumulated gain
	endfunction

	function automatic openadc_pkg::freq_count_t expected_freq(input int period_ns);
		return openadc_pkg::freq_count_t'(((1 << gate_log2) * slow_period) / period_ns);
	endfunction

	function automatic int expected_heartbeat();
		return 1 << (gate_log2 - 1); // Half the gate high time
	endfunction

	function automatic openadc_pkg::reg_data_t expected_status(input logic armed,
	                                                           input logic capturing,
	                                                           input logic trig);
		openadc_pkg::reg_data_t s;
		s                   = '0;
		s[`OADC_ST_ARMED]   = armed;
		s[`OADC_ST_IDLE]    = ~capturing;
		s[`OADC_ST_TRIG_IN] = trig;
		return s;
	endfunction

	// Compare tasks
	task automatic check_byte(input openadc_pkg::reg_data_t got, input openadc_pkg::reg_data_t exp,
	                          input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_freq(input openadc_pkg::freq_count_t got,
	                          input openadc_pkg::freq_count_t exp, input string what);
		int diff;
		diff = int'(got) - int'(exp);
		checks++;
		if (diff > 2 || diff < -2) begin // Two edges of slack at each gate end
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d +-2", $time, what, got, exp);
		end
	endtask

	task automatic check_samples(input openadc_pkg::sample_count_t got,
	                             input openadc_pkg::sample_count_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Host bus, called right after a falling edge
	task automatic reg_write(input openadc_pkg::reg_addr_t addr, input openadc_pkg::reg_data_t data);
		reg_addr  = addr;
		reg_wdata = data;
		reg_wr    = 1'b1;
		@(negedge slowclock);
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input openadc_pkg::reg_addr_t addr, output openadc_pkg::reg_data_t data);
		reg_addr = addr;
		reg_rd   = 1'b1;
		@(negedge slowclock);
		reg_rd = 1'b0;
		data   = reg_rdata; // Valid one cycle after the strobe
	endtask

	// Waits for the capture window and measures its length
	task automatic run_capture(input openadc_pkg::sample_count_t exp_len, input string what);
		int                         waited;
		logic                       prev_armed;
		openadc_pkg::sample_count_t len;
		waited     = 0;
		prev_armed = led_armed;
		while (led_capture !== 1'b1 && waited < 20) begin
			prev_armed = led_armed;
			@(negedge slowclock);
			waited++;
		end
		if (led_capture !== 1'b1) begin
			errors++;
			$display("%s: the capture window did not open within 20 cycles", what);
		end else begin
			check_level(prev_armed, 1'b1, {what, " armed before fire"});
			check_level(led_armed, 1'b0, {what, " armed at fire"}); // Same cycle as capture rise
			len = '0;
			while (led_capture === 1'b1 && len != 16'hffff) begin
				len++;
				@(negedge slowclock);
			end
			check_samples(len, exp_len, {what, " window length"});
		end
	endtask

	task automatic test_registers();
		logic [31:0]            r;
		openadc_pkg::reg_data_t lo;
		openadc_pkg::reg_data_t hi;
		reg_read(`OADC_REG_STATUS, lo);
		check_byte(lo, expected_status(1'b0, 1'b0, 1'b0), "status after reset");
		rand_bits(8, r);
		reg_write(`OADC_REG_GAIN, r[7:0]);
		reg_read(`OADC_REG_GAIN, lo);
		check_byte(lo, r[7:0], "gain readback");
		rand_bits(8, r);
		reg_write(`OADC_REG_SETTINGS, r[7:0] & ~(set_arm | set_now)); // Trigger stays idle
		reg_read(`OADC_REG_SETTINGS, lo);
		check_byte(lo, r[7:0] & ~(set_arm | set_now), "settings readback");
		reg_write(`OADC_REG_SETTINGS, 8'h00);
		rand_bits(16, r);
		reg_write(`OADC_REG_SAMPLES0, r[7:0]);
		reg_write(`OADC_REG_SAMPLES1, r[15:8]);
		reg_read(`OADC_REG_SAMPLES0, lo);
		reg_read(`OADC_REG_SAMPLES1, hi);
		check_samples({hi, lo}, r[15:0], "sample length readback");
	endtask

	task automatic test_pwm();
		logic [31:0] r;
		int          highs;
		for (int g = 0; g < num_gains; g++) begin
			rand_bits(8, r);
			reg_write(`OADC_REG_GAIN, r[7:0]);
			repeat (2) @(negedge slowclock); // New gain in the accumulator
			highs = 0;
			repeat (256) begin
				highs += int'(amp_gain);
				@(negedge slowclock);
			end
			check_byte(8'(highs), 8'(expected_pwm_highs(r[7:0])), "PWM high count");
		end
		reg_write(`OADC_REG_SETTINGS, set_hilo);
		check_level(amp_hilo, 1'b1, "amp_hilo after set");
		reg_write(`OADC_REG_SETTINGS, 8'h00);
		check_level(amp_hilo, 1'b0, "amp_hilo after clear");
	endtask

	task automatic test_heartbeat();
		logic start;
		int   n;
		repeat (2) begin
			start = led_heartbeat;
			while (led_heartbeat == start) @(negedge slowclock); // Align to a toggle
			start = led_heartbeat;
			n     = 0;
			while (led_heartbeat == start) begin
				@(negedge slowclock);
				n++;
			end
			check_samples(16'(n), 16'(expected_heartbeat()), "heartbeat half period");
		end
	endtask

	task automatic test_frequency(input int period_ns);
		openadc_pkg::freq_count_t freq;
		openadc_pkg::reg_data_t   data;
		dut_half = period_ns / 2.0;
		repeat (3 * gate_period) @(negedge slowclock); // At least one full new window
		for (int b = 0; b < 4; b++) begin
			reg_read(openadc_pkg::reg_addr_t'(`OADC_REG_FREQ0 + b), data);
			freq[8*b +: 8] = data; // LSB first
		end
		check_freq(freq, expected_freq(period_ns), $sformatf("frequency at %0d ns", period_ns));
	endtask

	task automatic test_trigger();
		logic [31:0]                r;
		openadc_pkg::sample_count_t len;
		openadc_pkg::reg_data_t     data;
		rand_bits(4, r);
		len = 16'(r[3:0]) + 16'd3;
		reg_write(`OADC_REG_SAMPLES0, len[7:0]);
		reg_write(`OADC_REG_SAMPLES1, len[15:8]);
		// High polarity trigger
		reg_write(`OADC_REG_SETTINGS, set_arm | set_high);
		repeat (3) @(negedge slowclock);
		check_level(led_armed, 1'b1, "armed after arm edge");
		check_level(led_capture, 1'b0, "capture before trigger");
		dut_trigger = 1'b1;
		run_capture(len, "external trigger");
		dut_trigger = 1'b0;
		repeat (4) @(negedge slowclock); // Sync flops settle
		reg_read(`OADC_REG_STATUS, data);
		check_byte(data, expected_status(1'b0, 1'b0, 1'b0), "status after capture");
		// Force trigger, arm needs a fresh rising edge
		reg_write(`OADC_REG_SETTINGS, set_high);
		reg_write(`OADC_REG_SETTINGS, set_arm | set_high | set_now);
		run_capture(len, "forced trigger");
		// Wait for inactive with trigger already high
		reg_write(`OADC_REG_SETTINGS, set_high);
		dut_trigger = 1'b1;
		repeat (4) @(negedge slowclock);
		reg_write(`OADC_REG_SETTINGS, set_arm | set_high | set_wait);
		repeat (20) begin
			@(negedge slowclock);
			check_level(led_capture, 1'b0, "capture while trigger stays active");
		end
		check_level(led_armed, 1'b1, "armed while waiting for inactive trigger");
		reg_read(`OADC_REG_STATUS, data); // Armed and trigger input both visible
		check_byte(data, expected_status(1'b1, 1'b0, 1'b1), "status while waiting");
		dut_trigger = 1'b0;
		repeat (6) begin
			@(negedge slowclock);
			check_level(led_capture, 1'b0, "capture while trigger low");
		end
		dut_trigger = 1'b1;
		run_capture(len, "trigger after inactive");
		dut_trigger = 1'b0;
		reg_write(`OADC_REG_SETTINGS, 8'h00);
	endtask

	initial begin
		errors       = 0;
		checks       = 0;
		lfsr         = 32'h54c2;
		freq_measure = 1'b0; // Reset held from time zero
		dut_trigger  = 1'b0;
		reg_addr     = '0;
		reg_wdata    = '0;
		reg_wr       = 1'b0;
		reg_rd       = 1'b0;
		repeat (5) @(negedge slowclock);
		freq_measure = 1'b1;
		@(negedge slowclock);
		test_registers();
		test_pwm();
		test_heartbeat();
		test_frequency(24);
		test_frequency(60);
		test_trigger();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+hdl
hdl/openadc_pkg.sv
hdl/timebase.sv
hdl/extclk_counter.sv
hdl/trigger_unit.sv
hdl/control_regs.sv
hdl/openadc_top.sv
test/tb_openadc.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_openadc -f files.f -o sim_openadc \
	&& ./obj_dir/sim_openadc > sim.log 2>&1 \
	|| { echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
